// File: hw/obi_pkg.sv
// OBI data bus types
`default_nettype none

package obi_pkg;

  // Checksum widths
  localparam int ACHK_W = 12;
  localparam int RCHK_W = 5;

  typedef logic [31:0]       addr_t;
  typedef logic [31:0]       data_t;
  typedef logic [3:0]        be_t;
  typedef logic [2:0]        prot_t;
  typedef logic [1:0]        memtype_t;
  typedef logic [5:0]        atop_t;
  typedef logic [ACHK_W-1:0] achk_t;
  typedef logic [RCHK_W-1:0] rchk_t;

  // Request packet without the checksum, which travels on its own wire
  typedef struct packed {
    addr_t    addr;
    logic     we;
    be_t      be;
    prot_t    prot;
    memtype_t memtype;
    logic     dbg;
    data_t    wdata;
  } obi_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
    rchk_t rchk;
  } obi_resp_t;

endpackage

`default_nettype wire

// File: hw/integrity_pkg.sv
// Integrity unit definitions
`default_nettype none

package integrity_pkg;

  // Outstanding requests allowed on the bus
  localparam int ATTR_DEPTH = 2;
  localparam int ATTR_PTR_W = (ATTR_DEPTH > 1) ? $clog2(ATTR_DEPTH) : 1;
  localparam int ATTR_CNT_W = $clog2(ATTR_DEPTH + 1);

  // Error/exokay bit in the response checksum
  localparam int RCHK_ERR_BIT = 4;

  // Attributes kept per accepted request
  typedef struct packed {
    logic store;
    logic gnt_err;
  } req_attr_t;

  // Faults seen in one cycle
  typedef struct packed {
    logic gnt;
    logic rvalid;
    logic rchk;
  } fault_t;

endpackage

`default_nettype wire

// File: hw/achk_gen.sv
// Request checksum generator
`timescale 1ns/1ps
`default_nettype none

module achk_gen (
  input  logic              req,
  input  obi_pkg::obi_req_t req_pkt,
  output obi_pkg::achk_t    achk,
  output logic              reqpar
);
  import obi_pkg::*;

  // Atomics are not supported
  atop_t atop;

  assign atop = '0;

  always_comb begin
    achk = '0;
    // One parity bit per address byte and per write-data byte
    for (int i = 0; i < 4; i++) begin
      achk[i]     = ^req_pkt.addr[8*i +: 8];
      achk[8 + i] = ^req_pkt.wdata[8*i +: 8];
    end
    achk[4] = ~^{req_pkt.prot, req_pkt.memtype};
    achk[5] = ~^{req_pkt.be, req_pkt.we};
    achk[6] = ~^req_pkt.dbg;
    achk[7] = ^atop;
  end

  // Request parity is the inverse of the request strobe
  assign reqpar = ~req;

endmodule

`default_nettype wire

// File: hw/rchk_check.sv
// Response checksum check
`timescale 1ns/1ps
`default_nettype none

module rchk_check (
  input  logic               rvalid,
  input  obi_pkg::obi_resp_t resp,
  input  logic               is_store,
  input  logic               enabled,
  output logic               rchk_fault
);
  import obi_pkg::*;
  import integrity_pkg::*;

  rchk_t rchk_calc;
  logic  exokay;
  logic  mismatch;

  // No exclusive accesses, so exokay never comes back set
  assign exokay = 1'b0;

  always_comb begin
    rchk_calc = '0;
    for (int i = 0; i < 4; i++) begin
      rchk_calc[i] = ^resp.rdata[8*i +: 8];
    end
    rchk_calc[RCHK_ERR_BIT] = resp.err ^ exokay;
  end

  // Store responses carry no data, only the error bit is protected
  assign mismatch = is_store ?
                    (resp.rchk[RCHK_ERR_BIT] != rchk_calc[RCHK_ERR_BIT]) :
                    (resp.rchk != rchk_calc);

  assign rchk_fault = rvalid && enabled && mismatch;

endmodule

`default_nettype wire

// File: hw/req_attr_fifo.sv
// Outstanding request attribute buffer
`timescale 1ns/1ps
`default_nettype none

module req_attr_fifo (
  input  logic                    clk_i,
  input  logic                    rst,
  input  logic                    push,
  input  integrity_pkg::req_attr_t push_attr,
  input  logic                    pop,
  output integrity_pkg::req_attr_t head_attr,
  output logic                    full
);
  import integrity_pkg::*;

  req_attr_t             mem [ATTR_DEPTH];
  logic [ATTR_PTR_W-1:0] wr_ptr;
  logic [ATTR_PTR_W-1:0] rd_ptr;
  logic [ATTR_CNT_W-1:0] count;
  logic                  do_pop;

  // A response with nothing outstanding is ignored
  assign do_pop = pop && (count != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= push_attr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ATTR_PTR_W'(ATTR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ATTR_PTR_W'(ATTR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push && !do_pop) begin
        count <= count + 1'b1;
      end else if (!push && do_pop) begin
        count <= count - 1'b1;
      end
    end
  end

  assign head_attr = mem[rd_ptr];
  assign full      = (count == ATTR_CNT_W'(ATTR_DEPTH));

endmodule

`default_nettype wire

// File: hw/integrity_ctrl.sv
// Integrity control and alert
`timescale 1ns/1ps
`default_nettype none

module integrity_ctrl (
  input  logic                    clk_i,
  input  logic                    rst,
  input  logic                    cfg_we,
  input  logic                    cfg_enable,
  input  logic                    core_req,
  input  logic                    bus_gnt,
  input  logic                    bus_gntpar,
  input  logic                    bus_rvalid,
  input  logic                    bus_rvalidpar,
  input  logic                    fifo_full,
  input  logic                    rchk_fault,
  input  integrity_pkg::req_attr_t head_attr,
  output logic                    integrity_enabled,
  output logic                    bus_req,
  output logic                    core_gnt,
  output logic                    push,
  output logic                    pop,
  output logic                    gnt_fault,
  output logic                    core_integrity_err,
  output logic                    alert_major
);
  import integrity_pkg::*;

  logic   enable_q;
  logic   alert_q;
  fault_t faults;

  // Integrity checking is on out of reset
  always_ff @(posedge clk_i) begin
    if (rst) begin
      enable_q <= 1'b1;
    end else if (cfg_we) begin
      enable_q <= cfg_enable;
    end
  end

  assign integrity_enabled = enable_q;

  // A response arriving this cycle frees a slot for the next request
  assign bus_req  = core_req && (!fifo_full || bus_rvalid);
  assign core_gnt = bus_req && bus_gnt;
  assign push     = core_gnt;
  assign pop      = bus_rvalid;

  // Parity wires must always be the inverse of their strobes
  assign faults.gnt    = (bus_gntpar == bus_gnt);
  assign faults.rvalid = (bus_rvalidpar == bus_rvalid);
  assign faults.rchk   = rchk_fault;

  assign gnt_fault = faults.gnt;

  assign core_integrity_err = bus_rvalid &&
                              (faults.rchk || faults.rvalid || head_attr.gnt_err);

  always_ff @(posedge clk_i) begin
    if (rst) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= |faults;
    end
  end

  assign alert_major = alert_q;

endmodule

`default_nettype wire

// File: hw/obi_integrity_top.sv
// Data bus integrity unit
`timescale 1ns/1ps
`default_nettype none

module obi_integrity_top (
  input  logic               clk_i,
  input  logic               rst,
  // Core load/store port
  input  logic               core_req,
  input  obi_pkg::obi_req_t  core_req_pkt,
  output logic               core_gnt,
  output logic               core_rvalid,
  output obi_pkg::data_t     core_rdata,
  output logic               core_err,
  output logic               core_integrity_err,
  // Configuration
  input  logic               cfg_we,
  input  logic               cfg_enable,
  output logic               integrity_enabled,
  // Memory bus
  output logic               bus_req,
  output logic               bus_reqpar,
  output obi_pkg::obi_req_t  bus_req_pkt,
  output obi_pkg::achk_t     bus_achk,
  input  logic               bus_gnt,
  input  logic               bus_gntpar,
  input  logic               bus_rvalid,
  input  logic               bus_rvalidpar,
  input  obi_pkg::obi_resp_t bus_resp,
  output logic               alert_major
);
  import integrity_pkg::*;

  req_attr_t push_attr;
  req_attr_t head_attr;
  logic      push;
  logic      pop;
  logic      fifo_full;
  logic      gnt_fault;
  logic      rchk_fault;

  // Request and response payloads pass through unchanged
  assign bus_req_pkt = core_req_pkt;
  assign core_rvalid = bus_rvalid;
  assign core_rdata  = bus_resp.rdata;
  assign core_err    = bus_resp.err;

  assign push_attr.store   = core_req_pkt.we;
  assign push_attr.gnt_err = gnt_fault;

  achk_gen i_achk_gen (
    .req     (bus_req),
    .req_pkt (core_req_pkt),
    .achk    (bus_achk),
    .reqpar  (bus_reqpar)
  );

  rchk_check i_rchk_check (
    .rvalid     (bus_rvalid),
    .resp       (bus_resp),
    .is_store   (head_attr.store),
    .enabled    (integrity_enabled),
    .rchk_fault (rchk_fault)
  );

  req_attr_fifo i_req_attr_fifo (
    .clk_i     (clk_i),
    .rst       (rst),
    .push      (push),
    .push_attr (push_attr),
    .pop       (pop),
    .head_attr (head_attr),
    .full      (fifo_full)
  );

  integrity_ctrl i_integrity_ctrl (
    .clk_i              (clk_i),
    .rst                (rst),
    .cfg_we             (cfg_we),
    .cfg_enable         (cfg_enable),
    .core_req           (core_req),
    .bus_gnt            (bus_gnt),
    .bus_gntpar         (bus_gntpar),
    .bus_rvalid         (bus_rvalid),
    .bus_rvalidpar      (bus_rvalidpar),
    .fifo_full          (fifo_full),
    .rchk_fault         (rchk_fault),
    .head_attr          (head_attr),
    .integrity_enabled  (integrity_enabled),
    .bus_req            (bus_req),
    .core_gnt           (core_gnt),
    .push               (push),
    .pop                (pop),
    .gnt_fault          (gnt_fault),
    .core_integrity_err (core_integrity_err),
    .alert_major        (alert_major)
  );

endmodule

`default_nettype wire

// File: verif/obi_integrity_asserts.sv
// Integrity unit assertions
`timescale 1ns/1ps
`default_nettype none

module obi_integrity_asserts (
  input logic              clk_i,
  input logic              rst,
  input logic              bus_req,
  input logic              bus_reqpar,
  input obi_pkg::obi_req_t bus_req_pkt,
  input obi_pkg::achk_t    bus_achk,
  input logic              bus_gnt,
  input logic              bus_gntpar,
  input logic              bus_rvalid,
  input logic              bus_rvalidpar,
  input logic              core_gnt,
  input logic              integrity_enabled,
  input logic              alert_major
);
  import obi_pkg::*;
  import integrity_pkg::*;

  int         fail_count = 0;
  logic [2:0] outstanding;
  logic       parity_fault;

  // Request checksum built from the highest bit down
  function automatic achk_t req_checksum(input obi_req_t p);
    return {^p.wdata[31:24], ^p.wdata[23:16], ^p.wdata[15:8], ^p.wdata[7:0],
            1'b0, !p.dbg, !(^{p.be, p.we}), !(^{p.prot, p.memtype}),
            ^p.addr[31:24], ^p.addr[23:16], ^p.addr[15:8], ^p.addr[7:0]};
  endfunction

  assign parity_fault = (bus_gntpar == bus_gnt) || (bus_rvalidpar == bus_rvalid);

  // Accepted requests still waiting for their response
  always_ff @(posedge clk_i) begin
    if (rst) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + 3'(bus_req && bus_gnt) - 3'(bus_rvalid);
    end
  end

  assert property (@(posedge clk_i) disable iff (rst)
    bus_req |-> bus_achk == req_checksum(bus_req_pkt))
    else begin
      fail_count = fail_count + 1;
      $error("bus_achk does not follow the request checksum rule");
    end

  assert property (@(posedge clk_i) bus_reqpar != bus_req)
    else begin
      fail_count = fail_count + 1;
      $error("bus_reqpar is not the inverse of bus_req");
    end

  assert property (@(posedge clk_i) disable iff (rst) parity_fault |=> alert_major)
    else begin
      fail_count = fail_count + 1;
      $error("alert_major missing one cycle after a parity fault");
    end

  assert property (@(posedge clk_i) rst |=> !alert_major && integrity_enabled)
    else begin
      fail_count = fail_count + 1;
      $error("alert_major or integrity_enabled wrong after reset");
    end

  assert property (@(posedge clk_i) disable iff (rst)
    (outstanding == 3'(ATTR_DEPTH) && !bus_rvalid) |-> !bus_req && !core_gnt)
    else begin
      fail_count = fail_count + 1;
      $error("request passed while the outstanding limit was reached");
    end

  assert property (@(posedge clk_i) disable iff (rst)
    outstanding <= 3'(ATTR_DEPTH))
    else begin
      fail_count = fail_count + 1;
      $error("too many outstanding requests");
    end

  assert property (@(posedge clk_i) disable iff (rst) !bus_gnt |-> !core_gnt)
    else begin
      fail_count = fail_count + 1;
      $error("core_gnt high without bus_gnt");
    end

endmodule

`default_nettype wire

// File: verif/tb_obi_integrity.sv
// Data bus integrity testbench
`timescale 1ns/1ps
`default_nettype none

module tb_obi_integrity;
  import obi_pkg::*;
  import integrity_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int NUM_CYCLES   = 400;
  localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + NUM_CYCLES);

  logic      clk_i = 1'b0;
  logic      rst;
  logic      core_req;
  obi_req_t  core_req_pkt;
  logic      core_gnt;
  logic      core_rvalid;
  data_t     core_rdata;
  logic      core_err;
  logic      core_integrity_err;
  logic      cfg_we;
  logic      cfg_enable;
  logic      integrity_enabled;
  logic      bus_req;
  logic      bus_reqpar;
  obi_req_t  bus_req_pkt;
  achk_t     bus_achk;
  logic      bus_gnt;
  logic      bus_gntpar;
  logic      bus_rvalid;
  logic      bus_rvalidpar;
  obi_resp_t bus_resp;
  logic      alert_major;

  // Responder and reference model state
  req_attr_t pending [$];
  int        wait_cnt;
  rchk_t     rchk_mask;
  logic      enable_model;
  logic      fault_prev;
  int        seed;
  int        errors;
  int        cycles;
  int        assert_fails;

  obi_integrity_top i_obi_integrity_top (.*);

  bind obi_integrity_top obi_integrity_asserts i_asserts (
    .clk_i             (clk_i),
    .rst               (rst),
    .bus_req           (bus_req),
    .bus_reqpar        (bus_reqpar),
    .bus_req_pkt       (bus_req_pkt),
    .bus_achk          (bus_achk),
    .bus_gnt           (bus_gnt),
    .bus_gntpar        (bus_gntpar),
    .bus_rvalid        (bus_rvalid),
    .bus_rvalidpar     (bus_rvalidpar),
    .core_gnt          (core_gnt),
    .integrity_enabled (integrity_enabled),
    .alert_major       (alert_major)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: stimulus still running after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // Response checksum with the error bit on top
  function automatic rchk_t calc_rchk(input data_t d, input logic e);
    return {e, ^d[31:24], ^d[23:16], ^d[15:8], ^d[7:0]};
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic got);
    assert (got === exp) else begin
      errors++;
      $display("error %s expected %h got %h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic compare_word(input string name, input logic [79:0] exp,
                              input logic [79:0] got);
    assert (got === exp) else begin
      errors++;
      $display("error %s expected %h got %h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic drive_cycle(input int n);
    logic [31:0] r;
    logic [31:0] r2;
    r  = $random(seed);
    r2 = $random(seed);
    core_req             = (r[2:0] != 3'd0);
    core_req_pkt.addr    = $random(seed);
    core_req_pkt.wdata   = $random(seed);
    core_req_pkt.we      = r[3];
    core_req_pkt.be      = r[7:4];
    core_req_pkt.prot    = r[10:8];
    core_req_pkt.memtype = r[12:11];
    core_req_pkt.dbg     = r[13];
    // Grant about three cycles in four with the grant parity flipped now and then
    bus_gnt    = r[14] | r[15];
    bus_gntpar = ~bus_gnt ^ (r[19:16] == 4'd0);
    bus_rvalid = 1'b0;
    if (pending.size() > 0) begin
      if (wait_cnt == 0) begin
        bus_rvalid = 1'b1;
      end else begin
        wait_cnt--;
      end
    end
    bus_rvalidpar  = ~bus_rvalid ^ (r[23:20] == 4'd0);
    bus_resp.rdata = $random(seed);
    bus_resp.err   = (r[26:24] == 3'd0);
    rchk_mask      = (r2[1:0] == 2'd0) ? r2[6:2] : '0;
    bus_resp.rchk  = calc_rchk(bus_resp.rdata, bus_resp.err) ^ rchk_mask;
    // Checking is switched off halfway through
    cfg_we     = (n == NUM_CYCLES / 2);
    cfg_enable = 1'b0;
  endtask

  task automatic check_cycle();
    req_attr_t head;
    req_attr_t attr;
    logic      cs_fault;
    logic      rv_fault;
    logic      gnt_fault;
    logic      exp_req;
    logic      exp_gnt;
    head      = '0;
    cs_fault  = 1'b0;
    rv_fault  = (bus_rvalidpar == bus_rvalid);
    gnt_fault = (bus_gntpar == bus_gnt);
    // With every slot taken only a response in the same cycle opens the way
    exp_req   = core_req && (pending.size() < ATTR_DEPTH || bus_rvalid);
    exp_gnt   = exp_req && bus_gnt;
    check_bit("bus_req", exp_req, bus_req);
    check_bit("core_gnt", exp_gnt, core_gnt);
    check_bit("core_rvalid", bus_rvalid, core_rvalid);
    if (exp_req) begin
      compare_word("bus_req_pkt", 80'(core_req_pkt), 80'(bus_req_pkt));
    end
    if (bus_rvalid) begin
      compare_word("core_rdata", 80'(bus_resp.rdata), 80'(core_rdata));
      check_bit("core_err", bus_resp.err, core_err);
      head = pending.pop_front();
      if (enable_model) begin
        cs_fault = head.store ? rchk_mask[4] : (rchk_mask != '0);
      end
      wait_cnt = $random(seed) & 3;
    end
    check_bit("core_integrity_err",
              bus_rvalid && (cs_fault || rv_fault || head.gnt_err), core_integrity_err);
    check_bit("alert_major", fault_prev, alert_major);
    check_bit("integrity_enabled", enable_model, integrity_enabled);
    if (exp_gnt) begin
      attr.store   = core_req_pkt.we;
      attr.gnt_err = gnt_fault;
      pending.push_back(attr);
    end
    fault_prev = gnt_fault || rv_fault || cs_fault;
    if (cfg_we) begin
      enable_model = cfg_enable;
    end
  endtask

  initial begin
    seed          = 32'hce0e8a7f;
    errors        = 0;
    cycles        = 0;
    wait_cnt      = 0;
    enable_model  = 1'b1;
    fault_prev    = 1'b0;
    rst           = 1'b1;
    core_req      = 1'b0;
    core_req_pkt  = '0;
    cfg_we        = 1'b0;
    cfg_enable    = 1'b1;
    bus_gnt       = 1'b0;
    bus_gntpar    = 1'b1;
    bus_rvalid    = 1'b0;
    bus_rvalidpar = 1'b1;
    bus_resp      = '0;
    rchk_mask     = '0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst = 1'b0;
    for (int n = 0; n < NUM_CYCLES; n++) begin
      drive_cycle(n);
      #1;
      check_cycle();
      @(negedge clk_i);
    end
    assert_fails = i_obi_integrity_top.i_asserts.fail_count;
    $display("Run done: %0d check errors, %0d assertion failures", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hw/obi_pkg.sv
hw/integrity_pkg.sv
hw/achk_gen.sv
hw/rchk_check.sv
hw/req_attr_fifo.sv
hw/integrity_ctrl.sv
hw/obi_integrity_top.sv
verif/obi_integrity_asserts.sv
verif/tb_obi_integrity.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_obi_integrity -f project.f

status=0
./obj_dir/Vtb_obi_integrity +verilator+error+limit+100000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "Simulation ended early, exit status $status"
  exit 1
fi
exit 0
